// File: cam_pkg.sv
////////////////////
// Shared definitions for the camera tracker
// Frame geometry, colour widths, orange thresholds
// Direction type and Wishbone register map
////////////////////

package cam_pkg;

  // Short lines keep simulation quick
  localparam int FRAME_WIDTH = 48;

  // RGB444 pixel, each channel widened to 8 bits
  localparam int PIXEL_W = 12;
  localparam int COLOR_W = 8;

  // Column counter width
  localparam int X_W = 8;

  // Orange and frame counters, one bit per LED on the board
  localparam int COUNT_W = 18;

  // Column boundaries of the three regions
  localparam logic [X_W-1:0] LEFT_END   = X_W'(FRAME_WIDTH / 3);
  localparam logic [X_W-1:0] CENTER_END = X_W'((2 * FRAME_WIDTH) / 3);

  // Orange colour window
  localparam logic [COLOR_W-1:0] RED_MIN_RESET = 8'hC0;
  localparam logic [COLOR_W-1:0] GREEN_LO      = 8'h40;
  localparam logic [COLOR_W-1:0] GREEN_HI      = 8'hA0;
  localparam logic [COLOR_W-1:0] BLUE_MAX      = 8'h50;

  // Orange pixels per frame needed to call a target
  localparam logic [COUNT_W-1:0] DETECT_MIN = COUNT_W'(8);

  // One-hot direction, zero when nothing is seen
  typedef enum logic [2:0] {
    DIR_NONE   = 3'b000,
    DIR_LEFT   = 3'b100,
    DIR_CENTER = 3'b010,
    DIR_RIGHT  = 3'b001
  } dir_t;

  // Wishbone word addressing
  localparam int WB_ADR_W = 2;
  localparam int WB_DAT_W = 32;

  localparam logic [WB_ADR_W-1:0] REG_STATUS  = 2'd0;
  localparam logic [WB_ADR_W-1:0] REG_COUNT   = 2'd1;
  localparam logic [WB_ADR_W-1:0] REG_RED_MIN = 2'd2;
  localparam logic [WB_ADR_W-1:0] REG_FRAMES  = 2'd3;

endpackage

// File: ov7670_capture.sv
////////////////////
// Camera byte capture
// Pairs bytes into RGB444 pixels, column and frame end
////////////////////

`timescale 1ns/10ps

module ov7670_capture (
  input  logic                        clk_25_vga,
  input  logic                        rst_n,
  input  logic                        vsync,
  input  logic                        href,
  input  logic [7:0]                  data,
  output logic                        pix_valid,
  output logic [cam_pkg::PIXEL_W-1:0] pix_data,
  output logic [cam_pkg::X_W-1:0]     pix_x,
  output logic                        frame_end
);

  // Registered camera pins
  logic       vsync_q;
  logic       vsync_prev;
  logic       href_q;
  logic [7:0] data_q;

  // Pairing state
  logic                       second_byte;
  logic [3:0]                 red_nib;
  logic [cam_pkg::X_W-1:0]    col;

  // Input register stage
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      vsync_q    <= 1'b0;
      vsync_prev <= 1'b0;
      href_q     <= 1'b0;
    end else begin
      vsync_q    <= vsync;
      vsync_prev <= vsync_q;
      href_q     <= href;
    end
    data_q <= data;
  end

  // Frame end on a vsync rising edge
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      frame_end <= 1'b0;
    end else begin
      frame_end <= vsync_q & ~vsync_prev;
    end
  end

  // Byte pairing and column tracking
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      second_byte <= 1'b0;
      col         <= '0;
      pix_valid   <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      if (!href_q) begin
        // Line gap, flush a half pair
        second_byte <= 1'b0;
        col         <= '0;
      end else if (!second_byte) begin
        second_byte <= 1'b1;
      end else begin
        second_byte <= 1'b0;
        pix_valid   <= 1'b1;
        col         <= col + 1'b1;
      end
    end
  end

  // Payload, red first then green and blue
  always_ff @(posedge clk_25_vga) begin
    if (href_q && !second_byte) begin
      red_nib <= data_q[3:0];
    end
    if (href_q && second_byte) begin
      pix_data <= {red_nib, data_q};
      pix_x    <= col;
    end
  end

endmodule

// File: target_finder.sv
////////////////////
// Orange colour test
// Recolours orange pixels white, one stage
////////////////////

`timescale 1ns/10ps

module target_finder (
  input  logic                        clk_25_vga,
  input  logic                        rst_n,
  input  logic                        pix_valid,
  input  logic [cam_pkg::PIXEL_W-1:0] pix_data,
  input  logic [cam_pkg::X_W-1:0]     pix_x,
  input  logic                        frame_end,
  input  logic [cam_pkg::COLOR_W-1:0] red_min,
  output logic                        out_valid,
  output logic [cam_pkg::COLOR_W-1:0] red_out,
  output logic [cam_pkg::COLOR_W-1:0] green_out,
  output logic [cam_pkg::COLOR_W-1:0] blue_out,
  output logic [cam_pkg::X_W-1:0]     out_x,
  output logic                        out_frame_end,
  output logic                        is_orange
);

  // Widened channels
  logic [cam_pkg::COLOR_W-1:0] red_w;
  logic [cam_pkg::COLOR_W-1:0] green_w;
  logic [cam_pkg::COLOR_W-1:0] blue_w;
  logic                        orange;

  // Nibble repeated into both halves
  assign red_w   = {pix_data[11:8], pix_data[11:8]};
  assign green_w = {pix_data[7:4], pix_data[7:4]};
  assign blue_w  = {pix_data[3:0], pix_data[3:0]};

  // Strong red, mid green, little blue
  assign orange = (red_w >= red_min) &&
                  (green_w >= cam_pkg::GREEN_LO) &&
                  (green_w <= cam_pkg::GREEN_HI) &&
                  (blue_w <= cam_pkg::BLUE_MAX);

  // Control flags
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      out_valid     <= 1'b0;
      out_frame_end <= 1'b0;
      is_orange     <= 1'b0;
    end else begin
      out_valid     <= pix_valid;
      // Keeps frame end in step with the pixels
      out_frame_end <= frame_end;
      is_orange     <= pix_valid & orange;
    end
  end

  // Pixel payload
  always_ff @(posedge clk_25_vga) begin
    out_x <= pix_x;
    if (orange) begin
      // Target shows up as white
      red_out   <= '1;
      green_out <= '1;
      blue_out  <= '1;
    end else begin
      red_out   <= red_w;
      green_out <= green_w;
      blue_out  <= blue_w;
    end
  end

endmodule

// File: classification.sv
////////////////////
// Orange counting per column third
// Detection and direction at frame end
////////////////////

`timescale 1ns/10ps

module classification (
  input  logic                        clk_25_vga,
  input  logic                        rst_n,
  input  logic                        pix_valid,
  input  logic [cam_pkg::X_W-1:0]     pix_x,
  input  logic                        is_orange,
  input  logic                        frame_end,
  output logic [cam_pkg::COUNT_W-1:0] orange_count,
  output cam_pkg::dir_t               direction,
  output logic                        orange_detected,
  output logic                        frame_done
);

  // Running counts per region
  logic [cam_pkg::COUNT_W-1:0] left_cnt;
  logic [cam_pkg::COUNT_W-1:0] center_cnt;
  logic [cam_pkg::COUNT_W-1:0] right_cnt;

  logic hit_left;
  logic hit_center;
  logic hit_right;

  // Two spare bits so the sum cannot wrap
  logic [cam_pkg::COUNT_W+1:0] total_wide;
  logic [cam_pkg::COUNT_W-1:0] total;
  cam_pkg::dir_t               best_dir;

  // Increment that sticks at all ones
  function automatic logic [cam_pkg::COUNT_W-1:0] bump(
    input logic [cam_pkg::COUNT_W-1:0] cnt,
    input logic                        en
  );
    if (en && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  // Region decode of an orange pixel
  assign hit_left   = pix_valid && is_orange && (pix_x < cam_pkg::LEFT_END);
  assign hit_center = pix_valid && is_orange && (pix_x >= cam_pkg::LEFT_END) &&
                      (pix_x < cam_pkg::CENTER_END);
  assign hit_right  = pix_valid && is_orange && (pix_x >= cam_pkg::CENTER_END);

  // Frame total, saturated
  assign total_wide = {2'b00, left_cnt} + {2'b00, center_cnt} + {2'b00, right_cnt};
  assign total      = (total_wide[cam_pkg::COUNT_W+1:cam_pkg::COUNT_W] != 2'b00) ?
                      '1 : total_wide[cam_pkg::COUNT_W-1:0];

  // Largest region wins; ties go centre first, then left
  always_comb begin
    if ((center_cnt >= left_cnt) && (center_cnt >= right_cnt)) begin
      best_dir = cam_pkg::DIR_CENTER;
    end else if (left_cnt >= right_cnt) begin
      best_dir = cam_pkg::DIR_LEFT;
    end else begin
      best_dir = cam_pkg::DIR_RIGHT;
    end
  end

  // Counting, restarted at each frame end
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      left_cnt   <= '0;
      center_cnt <= '0;
      right_cnt  <= '0;
    end else if (frame_end) begin
      // Pixel in the clear cycle opens the new frame
      left_cnt   <= bump('0, hit_left);
      center_cnt <= bump('0, hit_center);
      right_cnt  <= bump('0, hit_right);
    end else begin
      left_cnt   <= bump(left_cnt, hit_left);
      center_cnt <= bump(center_cnt, hit_center);
      right_cnt  <= bump(right_cnt, hit_right);
    end
  end

  // Results held until the next frame end
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      orange_count    <= '0;
      direction       <= cam_pkg::DIR_NONE;
      orange_detected <= 1'b0;
      frame_done      <= 1'b0;
    end else begin
      frame_done <= frame_end;
      if (frame_end) begin
        orange_count    <= total;
        orange_detected <= (total >= cam_pkg::DETECT_MIN);
        direction       <= (total >= cam_pkg::DETECT_MIN) ? best_dir : cam_pkg::DIR_NONE;
      end
    end
  end

endmodule

// File: wb_status_regs.sv
////////////////////
// Wishbone classic register block
// Status, count, red threshold, frame count
////////////////////

`timescale 1ns/10ps

module wb_status_regs (
  input  logic                         clk_25_vga,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [cam_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [cam_pkg::WB_DAT_W-1:0] wb_dat_w,
  input  logic [cam_pkg::COUNT_W-1:0]  orange_count,
  input  cam_pkg::dir_t                direction,
  input  logic                         orange_detected,
  input  logic                         frame_done,
  output logic [cam_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack,
  output logic [cam_pkg::COLOR_W-1:0]  red_min
);

  logic                         req;
  logic [cam_pkg::COUNT_W-1:0]  frame_cnt;
  logic [cam_pkg::WB_DAT_W-1:0] rd_word;

  // New request, not the one being acked
  assign req = wb_cyc && wb_stb && !wb_ack;

  // Read mux, unused bits zero
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      cam_pkg::REG_STATUS: begin
        rd_word[0]   = orange_detected;
        rd_word[3:1] = direction;
      end
      cam_pkg::REG_COUNT:   rd_word[cam_pkg::COUNT_W-1:0] = orange_count;
      cam_pkg::REG_RED_MIN: rd_word[cam_pkg::COLOR_W-1:0] = red_min;
      default:              rd_word[cam_pkg::COUNT_W-1:0] = frame_cnt;
    endcase
  end

  // Single-cycle ack
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // Read data valid with ack
  always_ff @(posedge clk_25_vga) begin
    if (req) begin
      wb_dat_r <= rd_word;
    end
  end

  // Only the threshold is writable
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      red_min <= cam_pkg::RED_MIN_RESET;
    end else if (req && wb_we && (wb_adr == cam_pkg::REG_RED_MIN)) begin
      red_min <= wb_dat_w[cam_pkg::COLOR_W-1:0];
    end
  end

  // Frames seen since reset
  always_ff @(posedge clk_25_vga) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

endmodule

// File: cam_tracker_top.sv
////////////////////
// Camera tracker top level
////////////////////

`timescale 1ns/10ps

module cam_tracker_top (
  input  logic                         clk_25_vga,
  input  logic                         rst_n,
  input  logic                         ov7670_vsync,
  input  logic                         ov7670_href,
  input  logic [7:0]                   ov7670_data,
  output logic [cam_pkg::COLOR_W-1:0]  vga_r,
  output logic [cam_pkg::COLOR_W-1:0]  vga_g,
  output logic [cam_pkg::COLOR_W-1:0]  vga_b,
  output logic                         pixel_valid,
  output logic                         led_orange,
  output cam_pkg::dir_t                led_direction,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [cam_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [cam_pkg::WB_DAT_W-1:0] wb_dat_w,
  output logic [cam_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack
);

  // Capture to finder
  logic                        pix_valid;
  logic [cam_pkg::PIXEL_W-1:0] pix_data;
  logic [cam_pkg::X_W-1:0]     pix_x;
  logic                        frame_end;

  // Finder to classifier
  logic [cam_pkg::X_W-1:0]     out_x;
  logic                        out_frame_end;
  logic                        is_orange;

  // Classifier to registers
  logic [cam_pkg::COUNT_W-1:0] orange_count;
  logic                        frame_done;
  logic [cam_pkg::COLOR_W-1:0] red_min;

  ov7670_capture u_capture (
    .clk_25_vga (clk_25_vga),
    .rst_n      (rst_n),
    .vsync      (ov7670_vsync),
    .href       (ov7670_href),
    .data       (ov7670_data),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_x      (pix_x),
    .frame_end  (frame_end)
  );

  // Recoloured stream goes straight to the video pins
  target_finder u_finder (
    .clk_25_vga    (clk_25_vga),
    .rst_n         (rst_n),
    .pix_valid     (pix_valid),
    .pix_data      (pix_data),
    .pix_x         (pix_x),
    .frame_end     (frame_end),
    .red_min       (red_min),
    .out_valid     (pixel_valid),
    .red_out       (vga_r),
    .green_out     (vga_g),
    .blue_out      (vga_b),
    .out_x         (out_x),
    .out_frame_end (out_frame_end),
    .is_orange     (is_orange)
  );

  // Direction and detect flag also drive the LEDs
  classification u_classifier (
    .clk_25_vga      (clk_25_vga),
    .rst_n           (rst_n),
    .pix_valid       (pixel_valid),
    .pix_x           (out_x),
    .is_orange       (is_orange),
    .frame_end       (out_frame_end),
    .orange_count    (orange_count),
    .direction       (led_direction),
    .orange_detected (led_orange),
    .frame_done      (frame_done)
  );

  wb_status_regs u_regs (
    .clk_25_vga      (clk_25_vga),
    .rst_n           (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .orange_count    (orange_count),
    .direction       (led_direction),
    .orange_detected (led_orange),
    .frame_done      (frame_done),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .red_min         (red_min)
  );

endmodule

// File: tb_cam_tracker.sv
////////////////////
// Camera tracker testbench
// Camera byte driver, Wishbone master, reference model
// Compare tasks and six directed tests
////////////////////

`timescale 1ns/10ps

module tb_cam_tracker;

  localparam int TIMEOUT = 200;
  localparam logic [cam_pkg::PIXEL_W-1:0] ORANGE_PIX = 12'hF72;

  logic                         clk_25_vga;
  logic                         rst_n;
  logic                         ov7670_vsync;
  logic                         ov7670_href;
  logic [7:0]                   ov7670_data;
  logic [cam_pkg::COLOR_W-1:0]  vga_r;
  logic [cam_pkg::COLOR_W-1:0]  vga_g;
  logic [cam_pkg::COLOR_W-1:0]  vga_b;
  logic                         pixel_valid;
  logic                         led_orange;
  cam_pkg::dir_t                led_direction;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [cam_pkg::WB_ADR_W-1:0] wb_adr;
  logic [cam_pkg::WB_DAT_W-1:0] wb_dat_w;
  logic [cam_pkg::WB_DAT_W-1:0] wb_dat_r;
  logic                         wb_ack;

  // Run bookkeeping
  integer seed;
  integer errors;
  integer checks;
  integer frames_sent;

  // Reference model state
  logic [cam_pkg::COLOR_W-1:0]   red_min_model;
  logic [cam_pkg::PIXEL_W-1:0]   line_pix[$];
  logic [3*cam_pkg::COLOR_W-1:0] exp_pix[$];
  logic [3*cam_pkg::COLOR_W-1:0] got_pix[$];
  logic [cam_pkg::COUNT_W-1:0]   cnt_left;
  logic [cam_pkg::COUNT_W-1:0]   cnt_center;
  logic [cam_pkg::COUNT_W-1:0]   cnt_right;
  logic [cam_pkg::COUNT_W-1:0]   exp_count;
  logic                          exp_detected;
  cam_pkg::dir_t                 exp_dir;
  logic [cam_pkg::WB_DAT_W-1:0]  rd_data;

  cam_tracker_top UUT (
    .clk_25_vga    (clk_25_vga),
    .rst_n         (rst_n),
    .ov7670_vsync  (ov7670_vsync),
    .ov7670_href   (ov7670_href),
    .ov7670_data   (ov7670_data),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .pixel_valid   (pixel_valid),
    .led_orange    (led_orange),
    .led_direction (led_direction),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  // 100 ns clock
  initial begin
    clk_25_vga = 1'b0;
    forever #50 clk_25_vga = ~clk_25_vga;
  end

  // Output stream sampled mid cycle
  always @(negedge clk_25_vga) begin
    if (rst_n && pixel_valid) begin
      got_pix.push_back({vga_r, vga_g, vga_b});
    end
  end

  // Nibble repeated into a full byte
  function automatic logic [7:0] widen(input logic [3:0] nib);
    return {nib, nib};
  endfunction

  function automatic logic orange_rule(input logic [11:0] pix, input logic [7:0] rmin);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = widen(pix[11:8]);
    g = widen(pix[7:4]);
    b = widen(pix[3:0]);
    return (r >= rmin) && (g >= cam_pkg::GREEN_LO) && (g <= cam_pkg::GREEN_HI) &&
           (b <= cam_pkg::BLUE_MAX);
  endfunction

  // Largest third wins with ties to centre then left
  function automatic cam_pkg::dir_t direction_rule(
    input logic [cam_pkg::COUNT_W-1:0] l,
    input logic [cam_pkg::COUNT_W-1:0] c,
    input logic [cam_pkg::COUNT_W-1:0] r
  );
    if ((l + c + r) < cam_pkg::DETECT_MIN) begin
      return cam_pkg::DIR_NONE;
    end else if ((c >= l) && (c >= r)) begin
      return cam_pkg::DIR_CENTER;
    end else if (l >= r) begin
      return cam_pkg::DIR_LEFT;
    end
    return cam_pkg::DIR_RIGHT;
  endfunction

  task automatic compare_pixel(input string name,
                               input logic [cam_pkg::COLOR_W-1:0] got_r,
                               input logic [cam_pkg::COLOR_W-1:0] got_g,
                               input logic [cam_pkg::COLOR_W-1:0] got_b,
                               input logic [cam_pkg::COLOR_W-1:0] exp_r,
                               input logic [cam_pkg::COLOR_W-1:0] exp_g,
                               input logic [cam_pkg::COLOR_W-1:0] exp_b);
    checks++;
    if ({got_r, got_g, got_b} !== {exp_r, exp_g, exp_b}) begin
      errors++;
      $display("[ERROR] %0t ns %s got %h %h %h expected %h %h %h", $time, name,
               got_r, got_g, got_b, exp_r, exp_g, exp_b);
    end
  endtask

  task automatic compare_word(input string name,
                              input logic [cam_pkg::WB_DAT_W-1:0] got,
                              input logic [cam_pkg::WB_DAT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_dir(input string name, input cam_pkg::dir_t got,
                             input cam_pkg::dir_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input integer err_start);
    $display("%s: %s, %0d errors", name, (errors == err_start) ? "passed" : "failed",
             errors - err_start);
  endtask

  task automatic wb_access(input logic we, input logic [cam_pkg::WB_ADR_W-1:0] adr,
                           input logic [cam_pkg::WB_DAT_W-1:0] wdata,
                           output logic [cam_pkg::WB_DAT_W-1:0] rdata);
    int waited;
    @(posedge clk_25_vga);
    #5;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    @(negedge clk_25_vga);
    while (!wb_ack && waited < TIMEOUT) begin
      @(negedge clk_25_vga);
      waited++;
    end
    rdata = wb_dat_r;
    if (!wb_ack) begin
      errors++;
      $display("Wishbone access to register %0d was never acknowledged", adr);
    end
    // Request dropped after the ack cycle
    @(posedge clk_25_vga);
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [cam_pkg::WB_ADR_W-1:0] adr,
                         output logic [cam_pkg::WB_DAT_W-1:0] rdata);
    wb_access(1'b0, adr, '0, rdata);
  endtask

  task automatic wb_write(input logic [cam_pkg::WB_ADR_W-1:0] adr,
                          input logic [cam_pkg::WB_DAT_W-1:0] wdata);
    logic [cam_pkg::WB_DAT_W-1:0] unused;
    wb_access(1'b1, adr, wdata, unused);
  endtask

  task automatic drive_byte(input logic [7:0] b);
    @(posedge clk_25_vga);
    #5;
    ov7670_href = 1'b1;
    ov7670_data = b;
  endtask

  // Blue at max keeps this noise line out of the orange window
  task automatic background_line();
    logic [31:0] rnd;
    line_pix.delete();
    for (int i = 0; i < cam_pkg::FRAME_WIDTH; i++) begin
      rnd = $random(seed);
      line_pix.push_back({rnd[11:4], 4'hF});
    end
  endtask

  // Drives line_pix and checks the recoloured stream in order
  task automatic send_line();
    logic [31:0] junk;
    logic [11:0] p;
    int          waited;
    exp_pix.delete();
    got_pix.delete();
    for (int i = 0; i < line_pix.size(); i++) begin
      p    = line_pix[i];
      junk = $random(seed);
      // High nibble of the red byte is don't care
      drive_byte({junk[7:4], p[11:8]});
      drive_byte(p[7:0]);
      if (orange_rule(p, red_min_model)) begin
        exp_pix.push_back(24'hFFFFFF);
        if (i < cam_pkg::FRAME_WIDTH / 3) begin
          cnt_left++;
        end else if (i < (2 * cam_pkg::FRAME_WIDTH) / 3) begin
          cnt_center++;
        end else begin
          cnt_right++;
        end
      end else begin
        exp_pix.push_back({widen(p[11:8]), widen(p[7:4]), widen(p[3:0])});
      end
    end
    @(posedge clk_25_vga);
    #5;
    ov7670_href = 1'b0;
    ov7670_data = 8'h00;
    waited = 0;
    while (got_pix.size() < exp_pix.size() && waited < TIMEOUT) begin
      @(posedge clk_25_vga);
      waited++;
    end
    if (got_pix.size() != exp_pix.size()) begin
      errors++;
      $display("Pixel stream gave %0d pixels where %0d were sent", got_pix.size(),
               exp_pix.size());
    end else begin
      for (int i = 0; i < exp_pix.size(); i++) begin
        compare_pixel("vga_rgb", got_pix[i][23:16], got_pix[i][15:8], got_pix[i][7:0],
                      exp_pix[i][23:16], exp_pix[i][15:8], exp_pix[i][7:0]);
      end
    end
  endtask

  // Pulses vsync and waits for the frame counter to move
  task automatic end_frame();
    int waited;
    @(posedge clk_25_vga);
    #5;
    ov7670_vsync = 1'b1;
    repeat (2) @(posedge clk_25_vga);
    #5;
    ov7670_vsync = 1'b0;
    frames_sent++;
    exp_count    = cnt_left + cnt_center + cnt_right;
    exp_detected = (exp_count >= cam_pkg::DETECT_MIN);
    exp_dir      = direction_rule(cnt_left, cnt_center, cnt_right);
    cnt_left     = '0;
    cnt_center   = '0;
    cnt_right    = '0;
    waited  = 0;
    rd_data = '0;
    while (rd_data != frames_sent && waited < TIMEOUT) begin
      wb_read(cam_pkg::REG_FRAMES, rd_data);
      waited++;
    end
    if (rd_data != frames_sent) begin
      errors++;
      $display("Frame counter did not reach %0d after the vsync pulse", frames_sent);
    end
  endtask

  // Frame results against the model
  task automatic check_frame();
    wb_read(cam_pkg::REG_COUNT, rd_data);
    compare_word("COUNT", rd_data, 32'(exp_count));
    wb_read(cam_pkg::REG_STATUS, rd_data);
    compare_word("STATUS", rd_data, {28'b0, exp_dir, exp_detected});
    compare_dir("STATUS direction", cam_pkg::dir_t'(rd_data[3:1]), exp_dir);
    compare_dir("led_direction", led_direction, exp_dir);
    compare_word("led_orange", 32'(led_orange), 32'(exp_detected));
  endtask

  task automatic reset_values();
    integer err_start;
    err_start = errors;
    wb_read(cam_pkg::REG_STATUS, rd_data);
    compare_word("STATUS", rd_data, '0);
    wb_read(cam_pkg::REG_COUNT, rd_data);
    compare_word("COUNT", rd_data, '0);
    wb_read(cam_pkg::REG_FRAMES, rd_data);
    compare_word("FRAMES", rd_data, '0);
    wb_read(cam_pkg::REG_RED_MIN, rd_data);
    compare_word("RED_MIN", rd_data, 32'(cam_pkg::RED_MIN_RESET));
    compare_word("pixel_valid", 32'(pixel_valid), '0);
    compare_word("led_orange", 32'(led_orange), '0);
    finish_test("reset state", err_start);
  endtask

  task automatic recolour_stream();
    integer      err_start;
    logic [31:0] rnd;
    err_start = errors;
    for (int n = 0; n < 2; n++) begin
      line_pix.delete();
      for (int i = 0; i < cam_pkg::FRAME_WIDTH; i++) begin
        rnd = $random(seed);
        line_pix.push_back(rnd[11:0]);
      end
      // Known values at the window edges
      line_pix[0] = ORANGE_PIX;
      line_pix[1] = 12'hC40;
      line_pix[2] = 12'hB72;
      line_pix[3] = 12'hFB2;
      line_pix[4] = 12'hF76;
      line_pix[5] = 12'hF45;
      line_pix[6] = 12'hFA0;
      send_line();
    end
    end_frame();
    check_frame();
    finish_test("recolouring", err_start);
  endtask

  task automatic direction_decision();
    integer err_start;
    err_start = errors;
    background_line();
    for (int i = 32; i < 44; i++) begin
      line_pix[i] = ORANGE_PIX;
    end
    line_pix[3] = ORANGE_PIX;
    send_line();
    end_frame();
    check_frame();
    compare_dir("led_direction", led_direction, cam_pkg::DIR_RIGHT);
    // Left and centre tied with right smaller
    background_line();
    for (int i = 0; i < 6; i++) begin
      line_pix[i]      = ORANGE_PIX;
      line_pix[16 + i] = ORANGE_PIX;
    end
    line_pix[40] = ORANGE_PIX;
    send_line();
    end_frame();
    check_frame();
    compare_dir("led_direction", led_direction, cam_pkg::DIR_CENTER);
    finish_test("detection and direction", err_start);
  endtask

  task automatic detect_threshold();
    integer err_start;
    err_start = errors;
    background_line();
    for (int i = 20; i < 25; i++) begin
      line_pix[i] = ORANGE_PIX;
    end
    send_line();
    end_frame();
    check_frame();
    compare_dir("led_direction", led_direction, cam_pkg::DIR_NONE);
    finish_test("detect threshold", err_start);
  endtask

  task automatic threshold_write();
    integer err_start;
    err_start = errors;
    wb_write(cam_pkg::REG_RED_MIN, 32'h0000_00F0);
    red_min_model = 8'hF0;
    wb_read(cam_pkg::REG_RED_MIN, rd_data);
    compare_word("RED_MIN", rd_data, 32'h0000_00F0);
    // Red 0xDD sits below the raised threshold
    line_pix.delete();
    for (int i = 0; i < cam_pkg::FRAME_WIDTH; i++) begin
      line_pix.push_back(12'hD72);
    end
    send_line();
    end_frame();
    check_frame();
    wb_read(cam_pkg::REG_COUNT, rd_data);
    compare_word("COUNT", rd_data, '0);
    wb_write(cam_pkg::REG_RED_MIN, 32'(cam_pkg::RED_MIN_RESET));
    red_min_model = cam_pkg::RED_MIN_RESET;
    finish_test("writable threshold", err_start);
  endtask

  task automatic frame_count();
    integer err_start;
    err_start = errors;
    wb_read(cam_pkg::REG_STATUS, rd_data);
    compare_word("STATUS", rd_data, {28'b0, exp_dir, exp_detected});
    wb_write(cam_pkg::REG_STATUS, 32'hFFFF_FFFF);
    wb_read(cam_pkg::REG_STATUS, rd_data);
    compare_word("STATUS", rd_data, {28'b0, exp_dir, exp_detected});
    wb_read(cam_pkg::REG_FRAMES, rd_data);
    compare_word("FRAMES", rd_data, frames_sent);
    finish_test("frame count and read-only", err_start);
  endtask

  initial begin
    seed          = 32'h86a4fb27;
    errors        = 0;
    checks        = 0;
    frames_sent   = 0;
    red_min_model = cam_pkg::RED_MIN_RESET;
    cnt_left      = '0;
    cnt_center    = '0;
    cnt_right     = '0;
    rst_n         = 1'b0;
    ov7670_vsync  = 1'b0;
    ov7670_href   = 1'b0;
    ov7670_data   = 8'h00;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    repeat (3) @(posedge clk_25_vga);
    #5;
    rst_n = 1'b1;
    reset_values();
    recolour_stream();
    direction_decision();
    detect_threshold();
    threshold_write();
    frame_count();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
cam_pkg.sv
ov7670_capture.sv
target_finder.sv
classification.sv
wb_status_regs.sv
cam_tracker_top.sv
tb_cam_tracker.sv

// File: run_sim.sh
#!/bin/sh
# Build the camera tracker testbench with Verilator, run it, and look for the pass line

verilator --binary --timing -Wno-fatal --top-module tb_cam_tracker \
  -f compile.f -o vsim_cam_tracker \
  && ./obj_dir/vsim_cam_tracker | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
